//--- logic/dispatch_pkg.sv
package dispatch_pkg;

    // group and structure sizes
    localparam int RENAME_WIDTH = 2;
    localparam int INTDQ_DISP_WID = 2;
    localparam int INTDQ_DEPTH = 8;
    localparam int IMMBUF_SIZE = 8;
    localparam int IMMBUF_READ_NUM = 2;
    localparam int IMMBUF_CLEAR_NUM = 2;
    // done entries retired from the buffer head per cycle
    localparam int IMMBUF_COMMIT_WID = 2;

    typedef logic [4:0] rob_idx_t;
    typedef logic [2:0] irob_idx_t;
    typedef logic [5:0] preg_idx_t;
    typedef logic [19:0] imm_t;
    typedef logic [3:0] ftq_idx_t;
    typedef logic [2:0] ftq_off_t;
    typedef logic [4:0] lreg_idx_t;

    typedef enum logic {
        INT_BLOCK = 1'b0,
        MEM_BLOCK = 1'b1
    } disp_que_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_BEQ = 3'd5,
        OP_BNE = 3'd6,
        OP_MV  = 3'd7
    } micro_op_e;

    typedef enum logic [1:0] {
        NONE         = 2'd0,
        ILLEGAL_INST = 2'd1,
        PC_MISALIGN  = 2'd2
    } except_e;

    typedef struct packed {
        ftq_idx_t  ftq_idx;
        ftq_off_t  ftq_offset;
        logic      is_rvc;
        logic      is_move;
        disp_que_e que_id;
        micro_op_e micro_op;
        logic      rd_wen;
        lreg_idx_t lrd_idx;
        preg_idx_t prd_idx;
        preg_idx_t prev_prd_idx;
        preg_idx_t prs_idx;
        logic      use_imm;
        imm_t      imm;
        logic      has_except;
        except_e   except_cause;
    } rename_info_t;

    typedef struct packed {
        ftq_idx_t  ftq_idx;
        ftq_off_t  ftq_offset;
        logic      is_rvc;
        logic      is_move;
        logic      has_rd;
        lreg_idx_t lrd_idx;
        preg_idx_t prd_idx;
        preg_idx_t prev_prd_idx;
    } rob_entry_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        irob_idx_t irob_idx;
        logic      rd_wen;
        preg_idx_t prd_idx;
        preg_idx_t prs_idx;
        logic      use_imm;
        micro_op_e micro_op;
    } intdq_entry_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        except_e  cause;
    } except_wb_t;

    // circular pointer advance, n never exceeds size
    function automatic int unsigned wrap_add(int unsigned ptr, int unsigned n,
                                             int unsigned size);
        int unsigned sum;
        sum = ptr + n;
        if (sum >= size) begin
            sum = sum - size;
        end
        return sum;
    endfunction

endpackage

//--- logic/queue_enq_if.sv
// enqueue side of the integer dispatch queue
interface dq_enq_if;
    import dispatch_pkg::*;

    logic                    o_can_enq;
    logic                    i_enq_vld;
    logic [RENAME_WIDTH-1:0] i_enq_req;
    intdq_entry_t            i_enq_data [RENAME_WIDTH];

    modport producer (input o_can_enq, output i_enq_vld, output i_enq_req, output i_enq_data);
    modport queue (output o_can_enq, input i_enq_vld, input i_enq_req, input i_enq_data);
endinterface

// allocation side of the immediate buffer
interface imm_alloc_if;
    import dispatch_pkg::*;

    logic                    o_can_enq;
    logic                    i_enq_vld;
    logic [RENAME_WIDTH-1:0] i_enq_req;
    imm_t                    i_enq_data [RENAME_WIDTH];
    // index handed back per slot, same cycle
    irob_idx_t               o_alloc_idx [RENAME_WIDTH];

    modport producer (input o_can_enq, output i_enq_vld, output i_enq_req,
                      output i_enq_data, input o_alloc_idx);
    modport buffer (output o_can_enq, input i_enq_vld, input i_enq_req,
                    input i_enq_data, output o_alloc_idx);
endinterface

//--- logic/disp_queue.sv
module disp_queue #(
    parameter int P_DEPTH = 8,
    parameter int P_OUT_NUM = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_flush,
    dq_enq_if.queue                    enq,
    input  logic [P_OUT_NUM-1:0]       i_deq_req,
    output logic [P_OUT_NUM-1:0]       o_can_deq,
    output dispatch_pkg::intdq_entry_t o_deq_data [P_OUT_NUM]
);
    import dispatch_pkg::*;

    localparam int AW = $clog2(P_DEPTH);
    localparam int CW = $clog2(P_DEPTH + 1);

    intdq_entry_t mem [P_DEPTH];

    logic [AW-1:0] head;
    logic [AW-1:0] tail;
    logic [CW-1:0] count;

    logic [AW-1:0]           wr_ptr [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] wr_en;
    logic [CW-1:0]           n_enq;
    logic [CW-1:0]           n_deq;

    // requested slots packed behind the tail in slot order
    always_comb begin
        int unsigned off;
        off = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            wr_ptr[i] = AW'(wrap_add(tail, off, P_DEPTH));
            wr_en[i] = enq.i_enq_vld && enq.i_enq_req[i];
            if (wr_en[i]) begin
                off = off + 1;
            end
        end
        n_enq = CW'(off);
    end

    // head window seen by the integer block
    always_comb begin
        for (int k = 0; k < P_OUT_NUM; k++) begin
            o_can_deq[k] = (count > CW'(k));
            o_deq_data[k] = mem[AW'(wrap_add(head, k, P_DEPTH))];
        end
    end

    always_comb begin
        int unsigned cnt;
        cnt = 0;
        for (int k = 0; k < P_OUT_NUM; k++) begin
            if (i_deq_req[k] && o_can_deq[k]) begin
                cnt = cnt + 1;
            end
        end
        n_deq = CW'(cnt);
    end

    assign enq.o_can_enq = (CW'(P_DEPTH) - count) >= CW'(RENAME_WIDTH);

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= AW'(wrap_add(head, n_deq, P_DEPTH));
            tail <= AW'(wrap_add(tail, n_enq, P_DEPTH));
            count <= count + n_enq - n_deq;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (wr_en[i]) begin
                mem[wr_ptr[i]] <= enq.i_enq_data[i];
            end
        end
    end

endmodule

//--- logic/imm_buffer.sv
module imm_buffer #(
    parameter int P_SIZE = 8
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       i_flush,
    imm_alloc_if.buffer                                alloc,
    input  dispatch_pkg::irob_idx_t                    i_read_idx [dispatch_pkg::IMMBUF_READ_NUM],
    input  logic [dispatch_pkg::IMMBUF_CLEAR_NUM-1:0]  i_clear_vld,
    input  dispatch_pkg::irob_idx_t                    i_clear_idx [dispatch_pkg::IMMBUF_CLEAR_NUM],
    output dispatch_pkg::imm_t                         o_read_data [dispatch_pkg::IMMBUF_READ_NUM]
);
    import dispatch_pkg::*;

    localparam int CW = $clog2(P_SIZE + 1);

    imm_t mem [P_SIZE];

    irob_idx_t         head;
    irob_idx_t         tail;
    logic [CW-1:0]     count;
    logic [P_SIZE-1:0] done;

    logic [RENAME_WIDTH-1:0] wr_en;
    logic [CW-1:0]           n_alloc;
    logic [CW-1:0]           n_free;

    // indices follow the tail in slot order
    always_comb begin
        int unsigned off;
        off = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            alloc.o_alloc_idx[i] = irob_idx_t'(wrap_add(tail, off, P_SIZE));
            wr_en[i] = alloc.i_enq_vld && alloc.i_enq_req[i];
            if (wr_en[i]) begin
                off = off + 1;
            end
        end
        n_alloc = CW'(off);
    end

    // retire only an unbroken run of done entries from the head
    always_comb begin
        int unsigned cnt;
        logic run;
        cnt = 0;
        run = 1'b1;
        for (int k = 0; k < IMMBUF_COMMIT_WID; k++) begin
            if (run && (count > CW'(k)) && done[wrap_add(head, k, P_SIZE)]) begin
                cnt = cnt + 1;
            end else begin
                run = 1'b0;
            end
        end
        n_free = CW'(cnt);
    end

    assign alloc.o_can_enq = (CW'(P_SIZE) - count) >= CW'(RENAME_WIDTH);

    always_comb begin
        for (int r = 0; r < IMMBUF_READ_NUM; r++) begin
            o_read_data[r] = mem[i_read_idx[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= irob_idx_t'(wrap_add(head, n_free, P_SIZE));
            tail <= irob_idx_t'(wrap_add(tail, n_alloc, P_SIZE));
            count <= count + n_alloc - n_free;
        end
    end

    // writeback clears mark done, a fresh allocation starts not done
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int c = 0; c < IMMBUF_CLEAR_NUM; c++) begin
                if (i_clear_vld[c]) begin
                    done[i_clear_idx[c]] <= 1'b1;
                end
            end
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (wr_en[i]) begin
                    done[alloc.o_alloc_idx[i]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (wr_en[i]) begin
                mem[alloc.o_alloc_idx[i]] <= alloc.i_enq_data[i];
            end
        end
    end

endmodule

//--- logic/dispatch.sv
module dispatch #(
    parameter int P_INTDQ_DEPTH = 8,
    parameter int P_IMMBUF_SIZE = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_squash_vld,
    output logic                                      o_stall,
    input  logic [dispatch_pkg::RENAME_WIDTH-1:0]     i_enq_vld,
    input  dispatch_pkg::rename_info_t                i_enq_inst [dispatch_pkg::RENAME_WIDTH],
    input  logic                                      i_can_insert_rob,
    input  dispatch_pkg::rob_idx_t                    i_alloc_rob_idx [dispatch_pkg::RENAME_WIDTH],
    output logic                                      o_insert_rob_vld,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0]     o_insert_rob_req,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0]     o_insert_rob_ismv,
    output dispatch_pkg::rob_entry_t                  o_new_rob_entry [dispatch_pkg::RENAME_WIDTH],
    output logic                                      o_exceptwb_vld,
    output dispatch_pkg::except_wb_t                  o_exceptwb_info,
    input  logic                                      i_intblock_stall,
    output logic [dispatch_pkg::INTDQ_DISP_WID-1:0]   o_intdq_deq_vld,
    output dispatch_pkg::intdq_entry_t                o_intdq_deq_info [dispatch_pkg::INTDQ_DISP_WID],
    input  dispatch_pkg::irob_idx_t                   i_immb_read_idx [dispatch_pkg::IMMBUF_READ_NUM],
    output dispatch_pkg::imm_t                        o_immb_read_data [dispatch_pkg::IMMBUF_READ_NUM],
    input  logic [dispatch_pkg::IMMBUF_CLEAR_NUM-1:0] i_immb_clear_vld,
    input  dispatch_pkg::irob_idx_t                   i_immb_clear_idx [dispatch_pkg::IMMBUF_CLEAR_NUM]
);
    import dispatch_pkg::*;

    dq_enq_if    dq_enq ();
    imm_alloc_if imm_alloc ();

    logic       can_dispatch;
    logic       exc_any;
    except_wb_t exc_sel;
    logic       exc_vld_r;
    except_wb_t exc_info_r;

    // whole group or nothing
    assign can_dispatch = i_can_insert_rob && dq_enq.o_can_enq && imm_alloc.o_can_enq;
    assign o_stall = i_enq_vld[0] && !can_dispatch;
    assign o_insert_rob_vld = can_dispatch;
    assign o_insert_rob_req = i_enq_vld;

    assign dq_enq.i_enq_vld = can_dispatch;
    assign imm_alloc.i_enq_vld = can_dispatch;

    for (genvar i = 0; i < RENAME_WIDTH; i++) begin : gen_slot
        assign o_insert_rob_ismv[i] = i_enq_inst[i].is_move;
        assign o_new_rob_entry[i] = '{
            ftq_idx:      i_enq_inst[i].ftq_idx,
            ftq_offset:   i_enq_inst[i].ftq_offset,
            is_rvc:       i_enq_inst[i].is_rvc,
            is_move:      i_enq_inst[i].is_move,
            has_rd:       i_enq_inst[i].rd_wen,
            lrd_idx:      i_enq_inst[i].lrd_idx,
            prd_idx:      i_enq_inst[i].prd_idx,
            prev_prd_idx: i_enq_inst[i].prev_prd_idx
        };

        // moves complete at rename, they skip the queue
        assign dq_enq.i_enq_req[i] = i_enq_vld[i] && (i_enq_inst[i].que_id == INT_BLOCK)
                                     && !i_enq_inst[i].is_move;
        assign dq_enq.i_enq_data[i] = '{
            rob_idx:  i_alloc_rob_idx[i],
            irob_idx: imm_alloc.o_alloc_idx[i],
            rd_wen:   i_enq_inst[i].rd_wen,
            prd_idx:  i_enq_inst[i].prd_idx,
            prs_idx:  i_enq_inst[i].prs_idx,
            use_imm:  i_enq_inst[i].use_imm,
            micro_op: i_enq_inst[i].micro_op
        };

        assign imm_alloc.i_enq_req[i] = i_enq_vld[i] && i_enq_inst[i].use_imm;
        assign imm_alloc.i_enq_data[i] = i_enq_inst[i].imm;
    end

    // lowest slot wins, so scan downward
    always_comb begin
        exc_any = 1'b0;
        exc_sel.rob_idx = i_alloc_rob_idx[0];
        exc_sel.cause = i_enq_inst[0].except_cause;
        for (int i = RENAME_WIDTH - 1; i >= 0; i--) begin
            if (i_enq_vld[i] && i_enq_inst[i].has_except) begin
                exc_any = 1'b1;
                exc_sel.rob_idx = i_alloc_rob_idx[i];
                exc_sel.cause = i_enq_inst[i].except_cause;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exc_vld_r <= 1'b0;
        end else begin
            exc_vld_r <= can_dispatch && exc_any;
        end
    end

    always_ff @(posedge clk) begin
        exc_info_r <= exc_sel;
    end

    assign o_exceptwb_vld = exc_vld_r;
    assign o_exceptwb_info = exc_info_r;

    disp_queue #(
        .P_DEPTH   (P_INTDQ_DEPTH),
        .P_OUT_NUM (INTDQ_DISP_WID)
    ) u_int_queue (
        .clk        (clk),
        .rst        (rst),
        .i_flush    (i_squash_vld),
        .enq        (dq_enq.queue),
        .i_deq_req  (i_intblock_stall ? '0 : o_intdq_deq_vld),
        .o_can_deq  (o_intdq_deq_vld),
        .o_deq_data (o_intdq_deq_info)
    );

    imm_buffer #(
        .P_SIZE (P_IMMBUF_SIZE)
    ) u_imm_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_flush     (i_squash_vld),
        .alloc       (imm_alloc.buffer),
        .i_read_idx  (i_immb_read_idx),
        .i_clear_vld (i_immb_clear_vld),
        .i_clear_idx (i_immb_clear_idx),
        .o_read_data (o_immb_read_data)
    );

endmodule

//--- logic/dispatch_top.sv
module dispatch_top #(
    parameter int P_INTDQ_DEPTH = dispatch_pkg::INTDQ_DEPTH,
    parameter int P_IMMBUF_SIZE = dispatch_pkg::IMMBUF_SIZE
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_squash_vld,
    output logic                                      o_stall,
    input  logic [dispatch_pkg::RENAME_WIDTH-1:0]     i_enq_vld,
    input  dispatch_pkg::rename_info_t                i_enq_inst [dispatch_pkg::RENAME_WIDTH],
    input  logic                                      i_can_insert_rob,
    input  dispatch_pkg::rob_idx_t                    i_alloc_rob_idx [dispatch_pkg::RENAME_WIDTH],
    output logic                                      o_insert_rob_vld,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0]     o_insert_rob_req,
    output logic [dispatch_pkg::RENAME_WIDTH-1:0]     o_insert_rob_ismv,
    output dispatch_pkg::rob_entry_t                  o_new_rob_entry [dispatch_pkg::RENAME_WIDTH],
    output logic                                      o_exceptwb_vld,
    output dispatch_pkg::except_wb_t                  o_exceptwb_info,
    input  logic                                      i_intblock_stall,
    output logic [dispatch_pkg::INTDQ_DISP_WID-1:0]   o_intdq_deq_vld,
    output dispatch_pkg::intdq_entry_t                o_intdq_deq_info [dispatch_pkg::INTDQ_DISP_WID],
    input  dispatch_pkg::irob_idx_t                   i_immb_read_idx [dispatch_pkg::IMMBUF_READ_NUM],
    output dispatch_pkg::imm_t                        o_immb_read_data [dispatch_pkg::IMMBUF_READ_NUM],
    input  logic [dispatch_pkg::IMMBUF_CLEAR_NUM-1:0] i_immb_clear_vld,
    input  dispatch_pkg::irob_idx_t                   i_immb_clear_idx [dispatch_pkg::IMMBUF_CLEAR_NUM]
);

    // structure sizes picked here and pushed down
    dispatch #(
        .P_INTDQ_DEPTH (P_INTDQ_DEPTH),
        .P_IMMBUF_SIZE (P_IMMBUF_SIZE)
    ) u_dispatch (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .o_stall           (o_stall),
        .i_enq_vld         (i_enq_vld),
        .i_enq_inst        (i_enq_inst),
        .i_can_insert_rob  (i_can_insert_rob),
        .i_alloc_rob_idx   (i_alloc_rob_idx),
        .o_insert_rob_vld  (o_insert_rob_vld),
        .o_insert_rob_req  (o_insert_rob_req),
        .o_insert_rob_ismv (o_insert_rob_ismv),
        .o_new_rob_entry   (o_new_rob_entry),
        .o_exceptwb_vld    (o_exceptwb_vld),
        .o_exceptwb_info   (o_exceptwb_info),
        .i_intblock_stall  (i_intblock_stall),
        .o_intdq_deq_vld   (o_intdq_deq_vld),
        .o_intdq_deq_info  (o_intdq_deq_info),
        .i_immb_read_idx   (i_immb_read_idx),
        .o_immb_read_data  (o_immb_read_data),
        .i_immb_clear_vld  (i_immb_clear_vld),
        .i_immb_clear_idx  (i_immb_clear_idx)
    );

endmodule

//--- tests/tb_dispatch.sv
module tb_dispatch;
    import dispatch_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int HOLD_LIMIT = 200;
    localparam int DRAIN_LIMIT = 500;

    logic clk = 1'b0;
    logic rst;
    logic i_squash_vld;
    logic o_stall;
    logic [RENAME_WIDTH-1:0] i_enq_vld;
    rename_info_t i_enq_inst [RENAME_WIDTH];
    logic i_can_insert_rob;
    rob_idx_t i_alloc_rob_idx [RENAME_WIDTH];
    logic o_insert_rob_vld;
    logic [RENAME_WIDTH-1:0] o_insert_rob_req;
    logic [RENAME_WIDTH-1:0] o_insert_rob_ismv;
    rob_entry_t o_new_rob_entry [RENAME_WIDTH];
    logic o_exceptwb_vld;
    except_wb_t o_exceptwb_info;
    logic i_intblock_stall;
    logic [INTDQ_DISP_WID-1:0] o_intdq_deq_vld;
    intdq_entry_t o_intdq_deq_info [INTDQ_DISP_WID];
    irob_idx_t i_immb_read_idx [IMMBUF_READ_NUM];
    imm_t o_immb_read_data [IMMBUF_READ_NUM];
    logic [IMMBUF_CLEAR_NUM-1:0] i_immb_clear_vld;
    irob_idx_t i_immb_clear_idx [IMMBUF_CLEAR_NUM];

    // reference model of queue and immediate buffer
    intdq_entry_t exp_q [$];
    irob_idx_t live [$];
    imm_t ib_val [IMMBUF_SIZE];
    logic ib_done [IMMBUF_SIZE];
    int ib_head;
    int ib_tail;
    int ib_count;
    int rob_ptr;
    logic exc_pend;
    except_wb_t exc_pend_info;
    logic stalled;
    logic squash_seen;
    logic [IMMBUF_READ_NUM-1:0] rd_chk;
    int hold_cnt;
    int checks;
    int errors;
    int n_groups;
    int n_deq;
    logic timed_out;

    dispatch_top i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail at %0t: %s", $time, what);
        end
    endtask

    function automatic rob_entry_t rob_fields_of(rename_info_t inst);
        rob_entry_t r;
        r.ftq_idx = inst.ftq_idx;
        r.ftq_offset = inst.ftq_offset;
        r.is_rvc = inst.is_rvc;
        r.is_move = inst.is_move;
        r.has_rd = inst.rd_wen;
        r.lrd_idx = inst.lrd_idx;
        r.prd_idx = inst.prd_idx;
        r.prev_prd_idx = inst.prev_prd_idx;
        return r;
    endfunction

    function automatic bit entry_matches(intdq_entry_t got, intdq_entry_t exp);
        bit ok;
        ok = (got.rob_idx == exp.rob_idx) && (got.rd_wen == exp.rd_wen)
             && (got.prd_idx == exp.prd_idx) && (got.prs_idx == exp.prs_idx)
             && (got.use_imm == exp.use_imm) && (got.micro_op == exp.micro_op);
        // buffer index only means something for immediate users
        if (exp.use_imm) begin
            ok = ok && (got.irob_idx == exp.irob_idx);
        end
        return ok;
    endfunction

    task automatic make_group(input bit drain);
        int n;
        rename_info_t inst;
        n = drain ? 0 : int'($urandom_range(0, RENAME_WIDTH));
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            inst.ftq_idx = ftq_idx_t'($urandom);
            inst.ftq_offset = ftq_off_t'($urandom);
            inst.is_rvc = 1'($urandom);
            inst.is_move = ($urandom_range(0, 99) < 20);
            inst.que_id = ($urandom_range(0, 3) == 0) ? MEM_BLOCK : INT_BLOCK;
            inst.micro_op = inst.is_move ? OP_MV : micro_op_e'($urandom_range(0, 6));
            inst.rd_wen = 1'($urandom);
            inst.lrd_idx = lreg_idx_t'($urandom);
            inst.prd_idx = preg_idx_t'($urandom);
            inst.prev_prd_idx = preg_idx_t'($urandom);
            inst.prs_idx = preg_idx_t'($urandom);
            inst.use_imm = ($urandom_range(0, 1) == 1);
            inst.imm = imm_t'($urandom);
            inst.has_except = ($urandom_range(0, 9) == 0);
            if (!inst.has_except) begin
                inst.except_cause = NONE;
            end else if ($urandom_range(0, 1) == 0) begin
                inst.except_cause = ILLEGAL_INST;
            end else begin
                inst.except_cause = PC_MISALIGN;
            end
            i_enq_inst[i] <= inst;
            i_alloc_rob_idx[i] <= rob_idx_t'(rob_ptr + i);
        end
        i_enq_vld <= RENAME_WIDTH'((1 << n) - 1);
    endtask

    // called on the rising edge, all inputs change here
    task automatic drive_cycle(input bit drain);
        bit squash;
        int j;
        squash = !drain && ($urandom_range(0, 99) < 2);
        i_squash_vld <= squash;
        i_can_insert_rob <= drain || ($urandom_range(0, 99) < 80);
        i_intblock_stall <= !drain && ($urandom_range(0, 99) < 30);
        if (squash) begin
            i_enq_vld <= '0;
            hold_cnt = 0;
        end else if (stalled) begin
            // rename holds the group
            hold_cnt++;
            if (hold_cnt > HOLD_LIMIT) begin
                $display("timeout: dispatch kept stalling for %0d cycles", hold_cnt);
                errors++;
                timed_out = 1'b1;
            end
        end else begin
            make_group(drain);
            hold_cnt = 0;
        end
        for (int r = 0; r < IMMBUF_READ_NUM; r++) begin
            if (live.size() > 0) begin
                j = $urandom_range(0, live.size() - 1);
                i_immb_read_idx[r] <= live[j];
                rd_chk[r] = 1'b1;
            end else begin
                i_immb_read_idx[r] <= irob_idx_t'($urandom);
                rd_chk[r] = 1'b0;
            end
        end
        // writeback clears of distinct live entries
        for (int c = 0; c < IMMBUF_CLEAR_NUM; c++) begin
            if (!squash && live.size() > 0 && (drain || $urandom_range(0, 99) < 40)) begin
                j = $urandom_range(0, live.size() - 1);
                i_immb_clear_idx[c] <= live[j];
                i_immb_clear_vld[c] <= 1'b1;
                live.delete(j);
            end else begin
                i_immb_clear_idx[c] <= irob_idx_t'($urandom);
                i_immb_clear_vld[c] <= 1'b0;
            end
        end
    endtask

    // called on the falling edge: compare, then step the model over the next edge
    task automatic check_and_step();
        logic acc;
        logic exc_any;
        except_wb_t exc_exp;
        irob_idx_t alloc_idx [RENAME_WIDTH];
        intdq_entry_t e;
        int n_pop;
        int n_ret;
        int idx;
        acc = i_can_insert_rob && (INTDQ_DEPTH - exp_q.size() >= RENAME_WIDTH)
              && (IMMBUF_SIZE - ib_count >= RENAME_WIDTH);
        check_true(o_insert_rob_vld == acc,
                   $sformatf("o_insert_rob_vld is %0b, expected %0b", o_insert_rob_vld, acc));
        check_true(o_stall == (i_enq_vld[0] && !acc),
                   $sformatf("o_stall is %0b with group %b and accept %0b",
                             o_stall, i_enq_vld, acc));
        if (acc) begin
            check_true(o_insert_rob_req == i_enq_vld,
                       $sformatf("o_insert_rob_req is %b, expected %b",
                                 o_insert_rob_req, i_enq_vld));
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_enq_vld[i]) begin
                    check_true(o_insert_rob_ismv[i] == i_enq_inst[i].is_move,
                               $sformatf("o_insert_rob_ismv[%0d] is wrong", i));
                    check_true(o_new_rob_entry[i] == rob_fields_of(i_enq_inst[i]),
                               $sformatf("ROB entry %0d is %h, expected %h", i,
                                         o_new_rob_entry[i], rob_fields_of(i_enq_inst[i])));
                end
            end
        end
        check_true(o_exceptwb_vld == exc_pend,
                   $sformatf("o_exceptwb_vld is %0b, expected %0b", o_exceptwb_vld, exc_pend));
        if (exc_pend && o_exceptwb_vld) begin
            check_true(o_exceptwb_info == exc_pend_info,
                       $sformatf("exception report is %h, expected %h",
                                 o_exceptwb_info, exc_pend_info));
        end
        if (squash_seen) begin
            check_true(o_intdq_deq_vld == '0, "integer queue still has entries after a squash");
            check_true(o_insert_rob_vld == i_can_insert_rob, "capacity not restored by a squash");
        end
        for (int k = 0; k < INTDQ_DISP_WID; k++) begin
            check_true(o_intdq_deq_vld[k] == (exp_q.size() > k),
                       $sformatf("o_intdq_deq_vld[%0d] is %0b with %0d entries queued",
                                 k, o_intdq_deq_vld[k], exp_q.size()));
            if (o_intdq_deq_vld[k] && exp_q.size() > k) begin
                check_true(entry_matches(o_intdq_deq_info[k], exp_q[k]),
                           $sformatf("queue slot %0d is %h, expected %h",
                                     k, o_intdq_deq_info[k], exp_q[k]));
            end
        end
        for (int r = 0; r < IMMBUF_READ_NUM; r++) begin
            if (rd_chk[r]) begin
                check_true(o_immb_read_data[r] == ib_val[i_immb_read_idx[r]],
                           $sformatf("immediate read of index %0d is %h, expected %h",
                                     i_immb_read_idx[r], o_immb_read_data[r],
                                     ib_val[i_immb_read_idx[r]]));
            end
        end

        if (i_squash_vld) begin
            exp_q.delete();
            live.delete();
            ib_head = 0;
            ib_tail = 0;
            ib_count = 0;
        end else begin
            if (!i_intblock_stall) begin
                n_pop = (exp_q.size() < INTDQ_DISP_WID) ? exp_q.size() : INTDQ_DISP_WID;
                for (int k = 0; k < n_pop; k++) begin
                    e = exp_q.pop_front();
                end
                n_deq += n_pop;
            end
            // head run of done entries, done bits as they were before this edge
            n_ret = 0;
            for (int k = 0; k < IMMBUF_COMMIT_WID; k++) begin
                idx = (ib_head + k) % IMMBUF_SIZE;
                if (n_ret == k && ib_count > k && ib_done[idx]) begin
                    n_ret++;
                end
            end
            ib_head = (ib_head + n_ret) % IMMBUF_SIZE;
            ib_count -= n_ret;
            for (int c = 0; c < IMMBUF_CLEAR_NUM; c++) begin
                if (i_immb_clear_vld[c]) begin
                    ib_done[i_immb_clear_idx[c]] = 1'b1;
                end
            end
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                alloc_idx[i] = '0;
                if (acc && i_enq_vld[i] && i_enq_inst[i].use_imm) begin
                    alloc_idx[i] = irob_idx_t'(ib_tail);
                    ib_val[ib_tail] = i_enq_inst[i].imm;
                    ib_done[ib_tail] = 1'b0;
                    live.push_back(irob_idx_t'(ib_tail));
                    ib_tail = (ib_tail + 1) % IMMBUF_SIZE;
                    ib_count++;
                end
            end
            // moves and memory ops never reach the integer queue
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (acc && i_enq_vld[i] && i_enq_inst[i].que_id == INT_BLOCK
                    && !i_enq_inst[i].is_move) begin
                    e.rob_idx = i_alloc_rob_idx[i];
                    e.irob_idx = alloc_idx[i];
                    e.rd_wen = i_enq_inst[i].rd_wen;
                    e.prd_idx = i_enq_inst[i].prd_idx;
                    e.prs_idx = i_enq_inst[i].prs_idx;
                    e.use_imm = i_enq_inst[i].use_imm;
                    e.micro_op = i_enq_inst[i].micro_op;
                    exp_q.push_back(e);
                end
            end
        end

        exc_any = 1'b0;
        exc_exp = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (!exc_any && i_enq_vld[i] && i_enq_inst[i].has_except) begin
                exc_any = 1'b1;
                exc_exp.rob_idx = i_alloc_rob_idx[i];
                exc_exp.cause = i_enq_inst[i].except_cause;
            end
        end
        exc_pend = acc && exc_any;
        exc_pend_info = exc_exp;
        if (acc && i_enq_vld != '0) begin
            rob_ptr += $countones(i_enq_vld);
            n_groups++;
        end
        stalled = i_enq_vld[0] && !acc;
        squash_seen = i_squash_vld;
    endtask

    initial begin
        int unsigned seed_ret;
        int drain_cnt;
        seed_ret = $urandom(32'hcdbe0bc2);
        exp_q.delete();
        live.delete();
        for (int i = 0; i < IMMBUF_SIZE; i++) begin
            ib_val[i] = '0;
            ib_done[i] = 1'b0;
        end
        ib_head = 0;
        ib_tail = 0;
        ib_count = 0;
        rob_ptr = 0;
        exc_pend = 1'b0;
        exc_pend_info = '0;
        stalled = 1'b0;
        squash_seen = 1'b0;
        rd_chk = '0;
        hold_cnt = 0;
        checks = 0;
        errors = 0;
        n_groups = 0;
        n_deq = 0;
        timed_out = 1'b0;

        rst = 1'b1;
        i_squash_vld = 1'b0;
        i_enq_vld = '0;
        i_can_insert_rob = 1'b0;
        i_intblock_stall = 1'b0;
        i_immb_clear_vld = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            i_enq_inst[i] = '0;
            i_alloc_rob_idx[i] = '0;
        end
        for (int r = 0; r < IMMBUF_READ_NUM; r++) begin
            i_immb_read_idx[r] = '0;
        end
        for (int c = 0; c < IMMBUF_CLEAR_NUM; c++) begin
            i_immb_clear_idx[c] = '0;
        end

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_true(!o_exceptwb_vld && o_intdq_deq_vld == '0, "outputs not idle during reset");
        @(posedge clk);
        rst <= 1'b0;
        drive_cycle(1'b0);

        for (int cyc = 0; cyc < NUM_CYCLES && !timed_out; cyc++) begin
            @(negedge clk);
            check_and_step();
            @(posedge clk);
            drive_cycle(1'b0);
        end

        // let everything retire
        drain_cnt = 0;
        while (!timed_out && (exp_q.size() != 0 || ib_count != 0 || stalled)) begin
            @(negedge clk);
            check_and_step();
            @(posedge clk);
            drive_cycle(1'b1);
            drain_cnt++;
            if (drain_cnt > DRAIN_LIMIT) begin
                $display("timeout: queue and immediate buffer did not drain");
                errors++;
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        check_and_step();

        $display("checks %0d, errors %0d, groups accepted %0d, entries dequeued %0d",
                 checks, errors, n_groups, n_deq);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/dispatch_pkg.sv
logic/queue_enq_if.sv
logic/disp_queue.sv
logic/imm_buffer.sv
logic/dispatch.sv
logic/dispatch_top.sv
tests/tb_dispatch.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dispatch -f sources.f

out=$(./obj_dir/Vtb_dispatch)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
